// ==== include/rlt_macros.svh ====
`ifndef RLT_MACROS_SVH
`define RLT_MACROS_SVH

// number of tiles watched by the monitor
`define RLT_NUM_TILES 8

// register ids per register file, integer and float alike
`define RLT_REG_ELS 32

// cycle counter width, latencies use the same width
`define RLT_CTR_W 32

// width of one destination coordinate
`define RLT_COORD_W 4

// AXI4-Lite address width
`define RLT_AXI_AW 8

`endif

// ==== src/rlt_pkg.sv ====
`default_nettype none

`include "rlt_macros.svh"

package rlt_pkg;

  // load kind, atomics are counted as integer loads
  typedef enum logic [1:0] {
    KIND_INT    = 2'd0,
    KIND_FLOAT  = 2'd1,
    KIND_ICACHE = 2'd2
  } rlt_kind_e;

  localparam int unsigned RLT_NUM_KINDS = 3;

  typedef struct packed {
    logic [$clog2(`RLT_NUM_TILES)-1:0] tile;
    rlt_kind_e                         kind;
    logic [$clog2(`RLT_REG_ELS)-1:0]   reg_id;
    logic [`RLT_COORD_W-1:0]           dest_x;
    logic [`RLT_COORD_W-1:0]           dest_y;
  } rlt_launch_s;

  typedef struct packed {
    logic [$clog2(`RLT_NUM_TILES)-1:0] tile;
    rlt_kind_e                         kind;
    logic [$clog2(`RLT_REG_ELS)-1:0]   reg_id;
  } rlt_return_s;

  typedef struct packed {
    rlt_launch_s            ev;
    logic [`RLT_CTR_W-1:0]  stamp;
  } rlt_stamped_launch_s;

  typedef struct packed {
    rlt_return_s            ev;
    logic [`RLT_CTR_W-1:0]  stamp;
  } rlt_stamped_return_s;

  // one outstanding load held by a tracker
  typedef struct packed {
    logic [`RLT_CTR_W-1:0]   start;
    logic [`RLT_COORD_W-1:0] dest_x;
    logic [`RLT_COORD_W-1:0] dest_y;
  } rlt_status_s;

  typedef struct packed {
    rlt_kind_e               kind;
    logic [`RLT_COORD_W-1:0] dest_x;
    logic [`RLT_COORD_W-1:0] dest_y;
    logic [`RLT_CTR_W-1:0]   latency;
  } rlt_record_s;

  typedef struct packed {
    logic [31:0]           count;
    logic [31:0]           sum;
    logic [`RLT_CTR_W-1:0] max;
  } rlt_stats_s;

  // master to slave
  typedef struct packed {
    logic [`RLT_AXI_AW-1:0] awaddr;
    logic                   awvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [`RLT_AXI_AW-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } rlt_axil_req_s;

  // slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } rlt_axil_rsp_s;

  typedef enum logic [1:0] {
    AXIL_IDLE  = 2'd0,
    AXIL_WDATA = 2'd1,
    AXIL_WRESP = 2'd2,
    AXIL_RDATA = 2'd3
  } rlt_axil_state_e;

endpackage

`default_nettype wire

// ==== src/rlt_event_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rlt_macros.svh"

module rlt_event_router (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic                         enable_i,
  input  wire logic                         launch_v_i,
  input  wire rlt_pkg::rlt_launch_s         launch_i,
  input  wire logic                         ret_v_i,
  input  wire rlt_pkg::rlt_return_s         ret_i,
  output logic [`RLT_NUM_TILES-1:0]         launch_v_o,
  output logic [`RLT_NUM_TILES-1:0]         ret_v_o,
  output rlt_pkg::rlt_stamped_launch_s      launch_o,
  output rlt_pkg::rlt_stamped_return_s      ret_o
);

  logic [`RLT_CTR_W-1:0] ctr_r;
  logic                  launch_take;
  logic                  ret_take;

  // events are dropped at the door while the monitor is disabled
  assign launch_take = launch_v_i & enable_i;
  assign ret_take    = ret_v_i & enable_i;

  // free-running cycle counter and one-hot steering to the trackers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctr_r      <= '0;
      launch_v_o <= '0;
      ret_v_o    <= '0;
    end else begin
      ctr_r      <= ctr_r + 1'b1;
      launch_v_o <= launch_take ? (`RLT_NUM_TILES'(1) << launch_i.tile) : '0;
      ret_v_o    <= ret_take ? (`RLT_NUM_TILES'(1) << ret_i.tile) : '0;
    end
  end

  // stamp is the counter value seen on the strobe cycle
  always_ff @(posedge clk_i) begin
    if (launch_v_i) begin
      launch_o <= '{ev: launch_i, stamp: ctr_r};
    end
    if (ret_v_i) begin
      ret_o <= '{ev: ret_i, stamp: ctr_r};
    end
  end

  onehot_valid_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(launch_v_o) && $onehot0(ret_v_o)
  );

endmodule

`default_nettype wire

// ==== src/rlt_tile_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rlt_macros.svh"

module rlt_tile_tracker (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic                         launch_v_i,
  input  wire rlt_pkg::rlt_stamped_launch_s launch_i,
  input  wire logic                         ret_v_i,
  input  wire rlt_pkg::rlt_stamped_return_s ret_i,
  output logic                              rec_v_o,
  output rlt_pkg::rlt_record_s              rec_o,
  input  wire logic                         rec_ready_i,
  output logic                              drop_o
);

  import rlt_pkg::*;

  rlt_status_s [`RLT_REG_ELS-1:0] int_st_r;
  rlt_status_s [`RLT_REG_ELS-1:0] float_st_r;
  rlt_status_s                    ic_st_r;
  logic [`RLT_REG_ELS-1:0]        int_v_r;
  logic [`RLT_REG_ELS-1:0]        float_v_r;
  logic                           ic_v_r;
  logic                           ic_set_r;

  rlt_status_s new_st;
  rlt_status_s hit_st;
  logic        hit;
  logic        buf_free;

  assign new_st = '{
    start:  launch_i.stamp,
    dest_x: launch_i.ev.dest_x,
    dest_y: launch_i.ev.dest_y
  };

  // lookup reads the registers, so a same-cycle launch is not seen yet
  always_comb begin
    hit    = 1'b0;
    hit_st = ic_st_r;
    case (ret_i.ev.kind)
      KIND_INT: begin
        hit    = int_v_r[ret_i.ev.reg_id];
        hit_st = int_st_r[ret_i.ev.reg_id];
      end
      KIND_FLOAT: begin
        hit    = float_v_r[ret_i.ev.reg_id];
        hit_st = float_st_r[ret_i.ev.reg_id];
      end
      KIND_ICACHE: begin
        hit = ic_v_r;
      end
      default: ;
    endcase
    hit = hit & ret_v_i;
  end

  // buffer can take a record if empty or being drained this cycle
  assign buf_free = ~rec_v_o | rec_ready_i;

  // valid bits, retire first and then let a launch claim the entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_v_r   <= '0;
      float_v_r <= '0;
      ic_v_r    <= 1'b0;
      ic_set_r  <= 1'b0;
    end else begin
      if (hit) begin
        case (ret_i.ev.kind)
          KIND_INT:    int_v_r[ret_i.ev.reg_id]   <= 1'b0;
          KIND_FLOAT:  float_v_r[ret_i.ev.reg_id] <= 1'b0;
          KIND_ICACHE: ic_v_r                     <= 1'b0;
          default: ;
        endcase
      end
      if (launch_v_i) begin
        case (launch_i.ev.kind)
          KIND_INT:    int_v_r[launch_i.ev.reg_id]   <= 1'b1;
          KIND_FLOAT:  float_v_r[launch_i.ev.reg_id] <= 1'b1;
          KIND_ICACHE: begin
            ic_v_r   <= 1'b1;
            ic_set_r <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch_v_i) begin
      case (launch_i.ev.kind)
        KIND_INT:    int_st_r[launch_i.ev.reg_id]   <= new_st;
        KIND_FLOAT:  float_st_r[launch_i.ev.reg_id] <= new_st;
        KIND_ICACHE: ic_st_r                        <= new_st;
        default: ;
      endcase
    end
  end

  // one-entry record buffer, a completion that finds it full is dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_v_o <= 1'b0;
      drop_o  <= 1'b0;
    end else begin
      drop_o <= hit & ~buf_free;
      if (hit & buf_free) begin
        rec_v_o <= 1'b1;
      end else if (rec_ready_i) begin
        rec_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit & buf_free) begin
      rec_o <= '{
        kind:    ret_i.ev.kind,
        dest_x:  hit_st.dest_x,
        dest_y:  hit_st.dest_y,
        latency: ret_i.stamp - hit_st.start
      };
    end
  end

  rec_stable_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rec_v_o && !rec_ready_i |=> rec_v_o && $stable(rec_o)
  );

  // an icache return needs an earlier icache launch on this tile
  icache_launched_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ret_v_i && (ret_i.ev.kind == KIND_ICACHE) |-> ic_set_r
  );

endmodule

`default_nettype wire

// ==== src/rlt_stats_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rlt_macros.svh"

module rlt_stats_collector (
  input  wire logic                                           clk_i,
  input  wire logic                                           reset_i,
  input  wire logic                                           clear_i,
  input  wire logic [`RLT_NUM_TILES-1:0]                      rec_v_i,
  input  wire rlt_pkg::rlt_record_s [`RLT_NUM_TILES-1:0]      rec_i,
  output logic [`RLT_NUM_TILES-1:0]                           rec_ready_o,
  input  wire logic [`RLT_NUM_TILES-1:0]                      drop_i,
  output rlt_pkg::rlt_stats_s [rlt_pkg::RLT_NUM_KINDS-1:0]    stats_o,
  output logic [31:0]                                         drops_o
);

  import rlt_pkg::*;

  localparam int unsigned TILE_W = $clog2(`RLT_NUM_TILES);

  logic [TILE_W-1:0] ptr_r;
  logic [TILE_W-1:0] scan_idx;
  logic [TILE_W-1:0] win;
  logic              grant_v;
  rlt_record_s       win_rec;
  logic [TILE_W:0]   drop_cnt;

  // rotating priority, search starts at the tile after the last winner
  always_comb begin
    grant_v     = 1'b0;
    win         = ptr_r;
    scan_idx    = ptr_r;
    rec_ready_o = '0;
    for (int i = 0; i < `RLT_NUM_TILES; i++) begin
      scan_idx = TILE_W'((int'(ptr_r) + i) % `RLT_NUM_TILES);
      if (!grant_v && rec_v_i[scan_idx]) begin
        grant_v = 1'b1;
        win     = scan_idx;
      end
    end
    if (grant_v) begin
      rec_ready_o[win] = 1'b1;
    end
  end

  assign win_rec = rec_i[win];

  // several trackers may drop in the same cycle
  always_comb begin
    drop_cnt = '0;
    for (int i = 0; i < `RLT_NUM_TILES; i++) begin
      drop_cnt = drop_cnt + (TILE_W+1)'(drop_i[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r <= '0;
    end else if (grant_v) begin
      ptr_r <= TILE_W'((int'(win) + 1) % `RLT_NUM_TILES);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      stats_o <= '0;
      drops_o <= '0;
    end else begin
      drops_o <= drops_o + 32'(drop_cnt);
      if (grant_v && (int'(win_rec.kind) < RLT_NUM_KINDS)) begin
        stats_o[win_rec.kind].count <= stats_o[win_rec.kind].count + 1'b1;
        stats_o[win_rec.kind].sum   <= stats_o[win_rec.kind].sum + win_rec.latency;
        if (win_rec.latency > stats_o[win_rec.kind].max) begin
          stats_o[win_rec.kind].max <= win_rec.latency;
        end
      end
    end
  end

  // at most one tracker is drained per cycle, and only one that is waiting
  grant_onehot_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(rec_ready_o) && ((rec_ready_o & ~rec_v_i) == '0)
  );

endmodule

`default_nettype wire

// ==== src/rlt_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rlt_macros.svh"

module rlt_axil_regs (
  input  wire logic                                         clk_i,
  input  wire logic                                         reset_i,
  input  wire rlt_pkg::rlt_axil_req_s                       axil_req_i,
  output rlt_pkg::rlt_axil_rsp_s                            axil_rsp_o,
  input  wire rlt_pkg::rlt_stats_s [rlt_pkg::RLT_NUM_KINDS-1:0] stats_i,
  input  wire logic [31:0]                                  drops_i,
  output logic                                              enable_o,
  output logic                                              clear_o
);

  import rlt_pkg::*;

  rlt_axil_state_e        w_state_r;
  rlt_axil_state_e        r_state_r;
  logic [`RLT_AXI_AW-1:0] waddr_r;
  logic [31:0]            rdata_r;
  logic [31:0]            rd_word;

  // write side, address first and then data
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_state_r <= AXIL_IDLE;
      enable_o  <= 1'b0;
      clear_o   <= 1'b0;
    end else begin
      clear_o <= 1'b0;
      case (w_state_r)
        AXIL_IDLE: begin
          if (axil_req_i.awvalid) begin
            w_state_r <= AXIL_WDATA;
          end
        end
        AXIL_WDATA: begin
          if (axil_req_i.wvalid) begin
            w_state_r <= AXIL_WRESP;
            // only the control register is writable
            if ((waddr_r == '0) && axil_req_i.wstrb[0]) begin
              enable_o <= axil_req_i.wdata[0];
              clear_o  <= axil_req_i.wdata[1];
            end
          end
        end
        AXIL_WRESP: begin
          if (axil_req_i.bready) begin
            w_state_r <= AXIL_IDLE;
          end
        end
        default: w_state_r <= AXIL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((w_state_r == AXIL_IDLE) && axil_req_i.awvalid) begin
      waddr_r <= axil_req_i.awaddr;
    end
  end

  // register map, holes read as zero
  always_comb begin
    rd_word = '0;
    case (axil_req_i.araddr)
      'h00: rd_word = {31'b0, enable_o};
      'h04: rd_word = drops_i;
      'h10: rd_word = stats_i[KIND_INT].count;
      'h14: rd_word = stats_i[KIND_INT].sum;
      'h18: rd_word = stats_i[KIND_INT].max;
      'h20: rd_word = stats_i[KIND_FLOAT].count;
      'h24: rd_word = stats_i[KIND_FLOAT].sum;
      'h28: rd_word = stats_i[KIND_FLOAT].max;
      'h30: rd_word = stats_i[KIND_ICACHE].count;
      'h34: rd_word = stats_i[KIND_ICACHE].sum;
      'h38: rd_word = stats_i[KIND_ICACHE].max;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_state_r <= AXIL_IDLE;
    end else if ((r_state_r == AXIL_IDLE) && axil_req_i.arvalid) begin
      r_state_r <= AXIL_RDATA;
    end else if ((r_state_r == AXIL_RDATA) && axil_req_i.rready) begin
      r_state_r <= AXIL_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((r_state_r == AXIL_IDLE) && axil_req_i.arvalid) begin
      rdata_r <= rd_word;
    end
  end

  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = (w_state_r == AXIL_IDLE);
    axil_rsp_o.wready  = (w_state_r == AXIL_WDATA);
    axil_rsp_o.bvalid  = (w_state_r == AXIL_WRESP);
    axil_rsp_o.bresp   = 2'b00;
    axil_rsp_o.arready = (r_state_r == AXIL_IDLE);
    axil_rsp_o.rvalid  = (r_state_r == AXIL_RDATA);
    axil_rsp_o.rresp   = 2'b00;
    axil_rsp_o.rdata   = rdata_r;
  end

  bvalid_after_write_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(axil_rsp_o.bvalid) |-> $past(axil_req_i.wvalid && axil_rsp_o.wready)
  );

endmodule

`default_nettype wire

// ==== src/rlt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rlt_macros.svh"

module rlt_top (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   launch_v_i,
  input  wire rlt_pkg::rlt_launch_s   launch_i,
  input  wire logic                   ret_v_i,
  input  wire rlt_pkg::rlt_return_s   ret_i,
  input  wire rlt_pkg::rlt_axil_req_s axil_req_i,
  output rlt_pkg::rlt_axil_rsp_s      axil_rsp_o
);

  import rlt_pkg::*;

  wire logic                              enable;
  wire logic                              clear;
  wire logic [`RLT_NUM_TILES-1:0]         launch_v;
  wire logic [`RLT_NUM_TILES-1:0]         ret_v;
  wire rlt_stamped_launch_s               launch_s;
  wire rlt_stamped_return_s               ret_s;
  wire logic [`RLT_NUM_TILES-1:0]         rec_v;
  wire logic [`RLT_NUM_TILES-1:0]         rec_ready;
  wire logic [`RLT_NUM_TILES-1:0]         drop;
  wire rlt_record_s [`RLT_NUM_TILES-1:0]  rec;
  wire rlt_stats_s [RLT_NUM_KINDS-1:0]    stats;
  wire logic [31:0]                       drops;

  rlt_event_router router_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .enable_i   (enable),
    .launch_v_i (launch_v_i),
    .launch_i   (launch_i),
    .ret_v_i    (ret_v_i),
    .ret_i      (ret_i),
    .launch_v_o (launch_v),
    .ret_v_o    (ret_v),
    .launch_o   (launch_s),
    .ret_o      (ret_s)
  );

  // stamped events are shared, the valid vectors pick the tile
  for (genvar g = 0; g < `RLT_NUM_TILES; g++) begin : g_tile
    rlt_tile_tracker tracker_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .launch_v_i  (launch_v[g]),
      .launch_i    (launch_s),
      .ret_v_i     (ret_v[g]),
      .ret_i       (ret_s),
      .rec_v_o     (rec_v[g]),
      .rec_o       (rec[g]),
      .rec_ready_i (rec_ready[g]),
      .drop_o      (drop[g])
    );
  end

  rlt_stats_collector collector_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .clear_i     (clear),
    .rec_v_i     (rec_v),
    .rec_i       (rec),
    .rec_ready_o (rec_ready),
    .drop_i      (drop),
    .stats_o     (stats),
    .drops_o     (drops)
  );

  rlt_axil_regs regs_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .stats_i    (stats),
    .drops_i    (drops),
    .enable_o   (enable),
    .clear_o    (clear)
  );

endmodule

`default_nettype wire

// ==== bench/rlt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rlt_macros.svh"

module rlt_tb;

  import rlt_pkg::*;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int NUM_KINDS      = 3;
  localparam int IDLE_CYCLES    = 20;
  localparam int NUM_RAND       = 40;

  // response bits the AXI tasks can wait on
  localparam int RSP_AWREADY = 0;
  localparam int RSP_WREADY  = 1;
  localparam int RSP_BVALID  = 2;
  localparam int RSP_ARREADY = 3;
  localparam int RSP_RVALID  = 4;

  // one stimulus row where gap counts cycles since the previous row
  typedef struct packed {
    logic [7:0] gap;
    logic       is_ret;
    logic [2:0] tile;
    logic [1:0] kind;
    logic [4:0] reg_id;
    logic [3:0] dx;
    logic [3:0] dy;
  } row_t;

  logic          clk_i;
  logic          reset_i;
  logic          launch_v;
  rlt_launch_s   launch;
  logic          ret_v;
  rlt_return_s   ret;
  rlt_axil_req_s axil_req;
  rlt_axil_rsp_s axil_rsp;

  int unsigned cyc = 0;
  row_t        rows[$];

  // reference model of outstanding loads and statistics
  bit          pend [`RLT_NUM_TILES][NUM_KINDS][`RLT_REG_ELS];
  int unsigned start_cyc [`RLT_NUM_TILES][NUM_KINDS][`RLT_REG_ELS];
  int unsigned exp_count [NUM_KINDS];
  int unsigned exp_sum [NUM_KINDS];
  int unsigned exp_max [NUM_KINDS];
  int unsigned matched;
  bit          enable_model;

  int    errors;
  int    checks;
  bit    timed_out;
  string kind_names [NUM_KINDS] = '{"int", "float", "icache"};

  rlt_top dut_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .launch_v_i (launch_v),
    .launch_i   (launch),
    .ret_v_i    (ret_v),
    .ret_i      (ret),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic finish_run();
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("gave up waiting for %s after %0d cycles", what, TIMEOUT_CYCLES);
    timed_out = 1'b1;
    finish_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, exp, got);
    end
  endtask

  function automatic logic rsp_bit(input int sel);
    case (sel)
      RSP_AWREADY: return axil_rsp.awready;
      RSP_WREADY:  return axil_rsp.wready;
      RSP_BVALID:  return axil_rsp.bvalid;
      RSP_ARREADY: return axil_rsp.arready;
      RSP_RVALID:  return axil_rsp.rvalid;
      default:     return 1'b0;
    endcase
  endfunction

  // sampled on the falling edge away from the DUT's flops
  task automatic wait_rsp(input int sel, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!rsp_bit(sel) && n < TIMEOUT_CYCLES);
    if (!rsp_bit(sel)) begin
      stop_on_timeout(what);
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    wait_rsp(RSP_AWREADY, "the write address handshake");
    @(posedge clk_i);
    axil_req.awvalid <= 1'b0;
    wait_rsp(RSP_WREADY, "the write data handshake");
    @(posedge clk_i);
    axil_req.wvalid <= 1'b0;
    wait_rsp(RSP_BVALID, "the write response");
    check_value("bresp", 32'h0, 32'(axil_rsp.bresp));
    @(posedge clk_i);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    wait_rsp(RSP_ARREADY, "the read address handshake");
    @(posedge clk_i);
    axil_req.arvalid <= 1'b0;
    wait_rsp(RSP_RVALID, "the read data");
    data = axil_rsp.rdata;
    check_value("rresp", 32'h0, 32'(axil_rsp.rresp));
    @(posedge clk_i);
    axil_req.rready <= 1'b0;
  endtask

  task automatic push_row(input int gap, input bit is_ret, input int tile,
                          input int kind, input int reg_id);
    row_t r;
    r.gap    = 8'(gap);
    r.is_ret = is_ret;
    r.tile   = 3'(tile);
    r.kind   = 2'(kind);
    r.reg_id = 5'(reg_id);
    r.dx     = 4'($urandom % 16);
    r.dy     = 4'($urandom % 16);
    rows.push_back(r);
  endtask

  // latency is the number of edges between launch and return strobes
  task automatic model_event(input row_t r);
    int          ri;
    int unsigned lat;
    ri = (r.kind == 2) ? 0 : int'(r.reg_id);
    if (enable_model && !r.is_ret) begin
      pend[r.tile][r.kind][ri]      = 1'b1;
      start_cyc[r.tile][r.kind][ri] = cyc;
    end else if (enable_model && pend[r.tile][r.kind][ri]) begin
      lat = cyc - start_cyc[r.tile][r.kind][ri];
      pend[r.tile][r.kind][ri] = 1'b0;
      exp_count[r.kind]++;
      exp_sum[r.kind] += lat;
      if (lat > exp_max[r.kind]) begin
        exp_max[r.kind] = lat;
      end
      matched++;
    end
  endtask

  task automatic apply_rows();
    foreach (rows[i]) begin
      for (int k = 1; k < rows[i].gap; k++) begin
        @(posedge clk_i);
        launch_v <= 1'b0;
        ret_v    <= 1'b0;
      end
      @(posedge clk_i);
      launch_v <= !rows[i].is_ret;
      ret_v    <= rows[i].is_ret;
      launch   <= '{tile: rows[i].tile, kind: rlt_kind_e'(rows[i].kind),
                    reg_id: rows[i].reg_id, dest_x: rows[i].dx, dest_y: rows[i].dy};
      ret      <= '{tile: rows[i].tile, kind: rlt_kind_e'(rows[i].kind),
                    reg_id: rows[i].reg_id};
      model_event(rows[i]);
    end
    @(posedge clk_i);
    launch_v <= 1'b0;
    ret_v    <= 1'b0;
    rows.delete();
    repeat (IDLE_CYCLES) @(posedge clk_i);
  endtask

  task automatic clear_model();
    for (int k = 0; k < NUM_KINDS; k++) begin
      exp_count[k] = 0;
      exp_sum[k]   = 0;
      exp_max[k]   = 0;
    end
    matched = 0;
  endtask

  task automatic check_stats();
    logic [31:0] got;
    logic [7:0]  base;
    for (int k = 0; k < NUM_KINDS; k++) begin
      base = 8'(16 * (k + 1));
      axil_read(base, got);
      check_value($sformatf("%s count", kind_names[k]), exp_count[k], got);
      axil_read(base + 8'h4, got);
      check_value($sformatf("%s sum", kind_names[k]), exp_sum[k], got);
      axil_read(base + 8'h8, got);
      check_value($sformatf("%s max", kind_names[k]), exp_max[k], got);
    end
  endtask

  initial begin : main
    row_t        launched [NUM_RAND];
    row_t        r;
    logic [31:0] got;
    logic [31:0] total;
    void'($urandom(32'h2f55_1ba0));
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    launch_v = 1'b0;
    launch   = '0;
    ret_v    = 1'b0;
    ret      = '0;
    axil_req = '0;
    errors   = 0;
    checks   = 0;
    enable_model = 1'b0;
    clear_model();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    // everything reads zero out of reset
    check_stats();
    axil_read(8'h04, got);
    check_value("drops", 32'h0, got);
    axil_read(8'h00, got);
    check_value("control", 32'h0, got);

    // events while disabled must not count
    push_row(1, 0, 1, 0, 3);
    push_row(2, 0, 4, 1, 10);
    push_row(5, 1, 1, 0, 3);
    push_row(3, 1, 4, 1, 10);
    apply_rows();
    check_stats();
    axil_write(8'h00, 32'h1);
    enable_model = 1'b1;
    axil_read(8'h00, got);
    check_value("control", 32'h1, got);
    push_row(1, 0, 1, 0, 3);
    push_row(2, 0, 4, 1, 10);
    push_row(1, 0, 2, 2, 0);
    push_row(6, 1, 1, 0, 3);
    push_row(3, 1, 2, 2, 0);
    push_row(4, 1, 4, 1, 10);
    apply_rows();
    check_stats();

    // an atomic counts as an integer load and is followed by random traffic
    push_row(2, 0, 5, 0, 17);
    push_row(9, 1, 5, 0, 17);
    for (int i = 0; i < NUM_RAND; i++) begin
      push_row(1 + $urandom % 4, 0, i % 8, (i / 8) % 3, $urandom % 32);
      launched[i] = rows[rows.size() - 1];
      if (i >= 3) begin
        r        = launched[i - 3];
        r.is_ret = 1'b1;
        r.gap    = 8'(1 + $urandom % 3);
        rows.push_back(r);
      end
    end
    for (int i = NUM_RAND - 3; i < NUM_RAND; i++) begin
      r        = launched[i];
      r.is_ret = 1'b1;
      r.gap    = 8'(1 + $urandom % 3);
      rows.push_back(r);
    end
    apply_rows();
    check_stats();

    // holes in the register map read as zero while statistics are nonzero
    axil_read(8'h08, got);
    check_value("unmapped 0x08", 32'h0, got);
    axil_read(8'h1c, got);
    check_value("unmapped 0x1c", 32'h0, got);

    // unmatched and repeated returns leave the statistics alone
    push_row(2, 0, 5, 1, 9);
    push_row(7, 1, 5, 1, 9);
    apply_rows();
    check_stats();
    push_row(2, 1, 5, 1, 9);
    push_row(1, 1, 6, 0, 30);
    push_row(1, 1, 0, 2, 0);
    apply_rows();
    check_stats();

    // two rounds of returns on every tile back to back
    for (int round = 0; round < 2; round++) begin
      for (int t = 0; t < `RLT_NUM_TILES; t++) begin
        push_row(1, 0, t, 0, 4 + round);
      end
      for (int t = 0; t < `RLT_NUM_TILES; t++) begin
        push_row(1, 1, t, 0, 4 + round);
      end
    end
    apply_rows();
    axil_read(8'h04, total);
    for (int k = 0; k < NUM_KINDS; k++) begin
      axil_read(8'(16 * (k + 1)), got);
      total = total + got;
    end
    check_value("drops plus completed counts", matched, total);

    // clear keeps enable set
    axil_write(8'h00, 32'h3);
    clear_model();
    check_stats();
    axil_read(8'h04, got);
    check_value("drops", 32'h0, got);
    axil_read(8'h00, got);
    check_value("control", 32'h1, got);

    finish_run();
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
src/rlt_pkg.sv
src/rlt_event_router.sv
src/rlt_tile_tracker.sv
src/rlt_stats_collector.sv
src/rlt_axil_regs.sv
src/rlt_top.sv
bench/rlt_tb.sv
